/* logic/ffp_pkg.sv */
// Feedforward pulser package with sample and length widths and pipeline latency constants
`default_nettype none

package ffp_pkg;

   // Sample width, signed two's complement
   localparam int FFP_DWI = 18;

   // Pulse length and the sequencer counters
   localparam int FFP_LENGTH_WI = 32;

   // Slew limit, unsigned step per clock
   localparam int FFP_SLEW_WI = 17;

   // Cycles from pulse enable until the length counter runs.
   // Covers setpoint magnitude, ramp accumulator and clamp stages
   localparam int FFP_PIPE_LAT = 3;

   // Cycles held back before the length expires so the fall can land on zero
   localparam int FFP_FALL_MARGIN = 5;

   // One output sample, shared by both axes
   typedef logic signed [FFP_DWI-1:0] ffp_sample_t;

endpackage : ffp_pkg

`default_nettype wire

/* logic/ffp_settings_if.sv */
// Pulse settings bundle from the shadow latch to the sequencer and both channels
`timescale 1ns/1ps
`default_nettype none

interface ffp_settings_if;
   import ffp_pkg::*;

   logic [FFP_LENGTH_WI-1:0] length;   // Total pulse length incl. rise and fall
   logic [FFP_SLEW_WI-1:0]   slew_lim; // Max magnitude step per cycle
   ffp_sample_t              setp_x;   // First axis setpoint
   ffp_sample_t              setp_y;   // Second axis setpoint

   // Shadow latch side
   modport src (
      output length,
      output slew_lim,
      output setp_x,
      output setp_y
   );

   // Consumers, sequencer uses only length
   modport dst (
      input  length,
      input  slew_lim,
      input  setp_x,
      input  setp_y
   );

endinterface : ffp_settings_if

`default_nettype wire

/* logic/ffp_settings_latch.sv */
// Shadow register set that freezes the pulse settings on an accepted start
`timescale 1ns/1ps
`default_nettype none

module ffp_settings_latch (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                capture,  // Start gated by not busy
   input  logic [ffp_pkg::FFP_LENGTH_WI-1:0]   length,
   input  logic [ffp_pkg::FFP_SLEW_WI-1:0]     slew_lim,
   input  ffp_pkg::ffp_sample_t                setp_x,
   input  ffp_pkg::ffp_sample_t                setp_y,
   ffp_settings_if.src                         cfg
);

   // Shadow copy
   // Runtime inputs may move at any time, the running pulse only sees
   // what was present on its own start cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg.length   <= '0;
         cfg.slew_lim <= '0;
         cfg.setp_x   <= '0;
         cfg.setp_y   <= '0;
      end else if (capture) begin
         cfg.length   <= length;
         cfg.slew_lim <= slew_lim;   // Must be nonzero
         cfg.setp_x   <= setp_x;
         cfg.setp_y   <= setp_y;
      end
   end

   // A zero slew would never rail, so the fall would never be scheduled
   a_slew_nonzero : assert property (
      @(posedge clk) disable iff (!rst_n)
      capture |=> (cfg.slew_lim != '0)
   ) else $error("pulse captured with zero slew limit");

endmodule : ffp_settings_latch

`default_nettype wire

/* logic/ffp_sequencer.sv */
// Pulse timer that owns busy, aligns to the channel pipeline and schedules the fall
`timescale 1ns/1ps
`default_nettype none

module ffp_sequencer (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         start,      // Ignored while a pulse runs
   ffp_settings_if.dst  cfg,
   input  logic         railed_x,   // Already one cycle late
   input  logic         railed_y,
   output logic         pulse_on,   // Busy level
   output logic         fall        // High from the fall cycle to pulse end
);
   import ffp_pkg::*;

   logic                     start_ok;
   logic [FFP_PIPE_LAT-1:0]  pipe_dly;     // Alignment shift register
   logic                     count_en;
   logic                     both_railed;
   logic [FFP_LENGTH_WI-1:0] len_cnt;
   logic [FFP_LENGTH_WI-1:0] rise_cnt;
   logic [FFP_LENGTH_WI-1:0] fall_t;       // len_cnt value that starts the fall
   logic [FFP_LENGTH_WI-1:0] fall_need;    // Rise plus margin
   logic                     fall_sched;
   logic [FFP_LENGTH_WI:0]   on_cyc;       // Busy duration for the length check

   assign start_ok    = start & ~pulse_on;
   assign count_en    = pipe_dly[FFP_PIPE_LAT-1] & pulse_on;
   assign both_railed = railed_x & railed_y;   // Slower axis decides
   assign fall_need   = rise_cnt + FFP_LENGTH_WI'(FFP_FALL_MARGIN);

   // Flushed on start so a tail from the last pulse cannot count early
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pipe_dly <= '0;
      end else if (start_ok) begin
         pipe_dly <= '0;
      end else begin
         pipe_dly <= {pipe_dly[FFP_PIPE_LAT-2:0], pulse_on};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pulse_on   <= 1'b0;
         fall       <= 1'b0;
         fall_sched <= 1'b0;
         len_cnt    <= '0;
         rise_cnt   <= '0;
         fall_t     <= '0;
      end else if (start_ok) begin
         pulse_on   <= 1'b1;
         fall       <= 1'b0;
         fall_sched <= 1'b0;
         len_cnt    <= '0;
         rise_cnt   <= '0;
         fall_t     <= '0;
      end else if (count_en) begin
         len_cnt <= len_cnt + 1'b1;

         // Length is strict, even with the fall unfinished
         if (len_cnt == cfg.length) begin
            pulse_on <= 1'b0;
            fall     <= 1'b0;
         end else if (fall_sched && (len_cnt >= fall_t)) begin
            fall <= 1'b1;
         end

         if (!fall_sched) begin
            if (both_railed) begin
               fall_sched <= 1'b1;
               // Fall mirrors the rise, ending a margin before length
               if (cfg.length > fall_need) begin
                  fall_t <= cfg.length - fall_need;
               end else begin
                  fall_t <= '0;        // Too short, fall at once
               end
            end else begin
               rise_cnt <= rise_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         on_cyc <= '0;
      end else if (!pulse_on) begin
         on_cyc <= '0;
      end else begin
         on_cyc <= on_cyc + 1'b1;
      end
   end

   // Alignment plus length+1 counted cycles
   a_busy_len : assert property (
      @(posedge clk) disable iff (!rst_n)
      pulse_on |-> (on_cyc < ((FFP_LENGTH_WI+1)'(cfg.length) + 4))
   ) else $error("busy held past length+4 cycles");

   a_fall_in_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      fall |-> pulse_on
   ) else $error("fall active outside a pulse");

endmodule : ffp_sequencer

`default_nettype wire

/* logic/ffp_slew_channel.sv */
// One axis of the pulser, slew-limited magnitude ramp with the setpoint sign restored
`timescale 1ns/1ps
`default_nettype none

module ffp_slew_channel (
   input  logic                 clk,
   input  logic                 rst_n,
   ffp_settings_if.dst          cfg,
   input  logic                 sel_y,      // Tie, picks setp_y over setp_x
   input  logic                 pulse_on,
   input  logic                 fall,
   output logic                 railed,     // To sequencer, one cycle late
   output ffp_pkg::ffp_sample_t out_sample
);
   import ffp_pkg::*;

   ffp_sample_t        setp_in;
   logic [FFP_DWI-1:0] setp_mag;     // Unsigned, holds 2**17 for the most negative
   logic               setp_neg;
   logic [FFP_DWI:0]   slew_ext;
   logic [FFP_DWI:0]   acc;          // Ramp value, may overshoot by one step
   logic [FFP_DWI-1:0] mag_clamp;
   logic [FFP_DWI-1:0] mag;
   ffp_sample_t        mag_s;
   logic               pulse_q;
   logic               rail_hit;
   logic               zero_hit;
   logic [FFP_DWI-1:0] out_mag;

   assign setp_in  = sel_y ? cfg.setp_y : cfg.setp_x;
   assign slew_ext = {{(FFP_DWI+1-FFP_SLEW_WI){1'b0}}, cfg.slew_lim};
   assign mag_s    = mag;

   // Overshoot never leaves this stage
   assign mag_clamp = (acc >= {1'b0, setp_mag}) ? setp_mag : acc[FFP_DWI-1:0];

   // Sign and magnitude split
   always_ff @(posedge clk) begin
      setp_neg <= setp_in[FFP_DWI-1];
      setp_mag <= setp_in[FFP_DWI-1] ? -setp_in : setp_in;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pulse_q <= 1'b0;
      end else begin
         pulse_q <= pulse_on;    // Setpoint magnitude valid from here
      end
   end

   // Ramp accumulator
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (!pulse_on) begin
         acc <= '0;
      end else if (fall) begin
         if (zero_hit || (acc <= slew_ext)) begin
            acc <= '0;                    // Saturate, never cross zero
         end else begin
            acc <= acc - slew_ext;
         end
      end else if (rail_hit) begin
         acc <= {1'b0, setp_mag};         // Hold the top
      end else begin
         acc <= acc + slew_ext;
      end
   end

   // Clamp stage with rail and zero flags
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mag      <= '0;
         rail_hit <= 1'b0;
         zero_hit <= 1'b0;
      end else if (!(pulse_on && pulse_q)) begin
         mag      <= '0;      // First pulse cycle too, setpoint still stale
         rail_hit <= 1'b0;
         zero_hit <= 1'b0;
      end else if (fall) begin
         rail_hit <= 1'b0;
         if (zero_hit || (acc == '0)) begin
            zero_hit <= 1'b1;  // Latched until pulse end
            mag      <= '0;
         end else begin
            mag <= mag_clamp;
         end
      end else begin
         rail_hit <= (acc >= {1'b0, setp_mag});
         mag      <= mag_clamp;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         railed <= 1'b0;
      end else begin
         railed <= rail_hit;     // Lines up with the delayed count enable
      end
   end

   // Output register, two behind acc
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_sample <= '0;
      end else begin
         out_sample <= setp_neg ? -mag_s : mag_s;
      end
   end

   assign out_mag = out_sample[FFP_DWI-1] ? -out_sample : out_sample;

   // Clamp must hold at the output, across the sign stage
   a_mag_bound : assert property (
      @(posedge clk) disable iff (!rst_n)
      (pulse_on && $past(pulse_on, FFP_PIPE_LAT)) |-> (out_mag <= setp_mag)
   ) else $error("output magnitude above setpoint");

   // Pipeline drains to zero shortly after busy drops
   a_zero_after : assert property (
      @(posedge clk) disable iff (!rst_n)
      $fell(pulse_on) |-> ##[0:FFP_PIPE_LAT-1] (out_sample == '0)
   ) else $error("output not zero after pulse end");

endmodule : ffp_slew_channel

`default_nettype wire

/* logic/ff_pulser.sv */
// Feedforward pulser top, two coherent slew-limited setpoint pulses from one start
`timescale 1ns/1ps
`default_nettype none

module ff_pulser (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              start,     // Accepted only when idle
   input  logic [ffp_pkg::FFP_LENGTH_WI-1:0] length,    // Whole pulse incl. rise and fall
   input  logic [ffp_pkg::FFP_SLEW_WI-1:0]   slew_lim,  // Nonzero
   input  ffp_pkg::ffp_sample_t              setp_x,
   input  ffp_pkg::ffp_sample_t              setp_y,
   output logic                              busy,
   output ffp_pkg::ffp_sample_t              out_x,
   output ffp_pkg::ffp_sample_t              out_y
);

   logic capture;
   logic pulse_on;
   logic fall;
   logic railed_x;
   logic railed_y;

   ffp_settings_if cfg_if ();

   assign capture = start & ~pulse_on;   // Same gate as the sequencer
   assign busy    = pulse_on;

   ffp_settings_latch u_latch (
      .clk      (clk),
      .rst_n    (rst_n),
      .capture  (capture),
      .length   (length),
      .slew_lim (slew_lim),
      .setp_x   (setp_x),
      .setp_y   (setp_y),
      .cfg      (cfg_if.src)
   );

   ffp_sequencer u_seq (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .cfg      (cfg_if.dst),
      .railed_x (railed_x),
      .railed_y (railed_y),
      .pulse_on (pulse_on),
      .fall     (fall)
   );

   // X axis
   ffp_slew_channel u_chan_x (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg_if.dst),
      .sel_y      (1'b0),
      .pulse_on   (pulse_on),
      .fall       (fall),
      .railed     (railed_x),
      .out_sample (out_x)
   );

   // Y axis
   ffp_slew_channel u_chan_y (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg_if.dst),
      .sel_y      (1'b1),
      .pulse_on   (pulse_on),
      .fall       (fall),
      .railed     (railed_y),
      .out_sample (out_y)
   );

endmodule : ff_pulser

`default_nettype wire

/* dv/ff_pulser_tb.sv */
// Table-driven self-checking testbench for the feedforward pulser with a waveform checker
`timescale 1ns/1ps
`default_nettype none

module ff_pulser_tb;
   import ffp_pkg::*;

   localparam int NUM_FIXED = 8;
   localparam int NUM_ROWS  = 12;
   localparam int ZERO_LAG  = 3;    // Idle samples after which outputs must read zero
   localparam int IDLE_GAP  = 6;

   typedef struct packed {
      int length;
      int slew;
      int sx;
      int sy;
      bit extra;                     // Second start in mid-pulse
   } stim_row_t;

   logic                     clk;
   logic                     rst_n;
   logic                     start;
   logic [FFP_LENGTH_WI-1:0] length;
   logic [FFP_SLEW_WI-1:0]   slew_lim;
   ffp_sample_t              setp_x;
   ffp_sample_t              setp_y;
   logic                     busy;
   ffp_sample_t              out_x;
   ffp_sample_t              out_y;

   stim_row_t   tbl [NUM_ROWS];
   integer      seed;
   int          cyc_cnt;
   int          cyc_limit;
   int          idle_cnt;           // Busy-low samples since the last pulse
   int          busy_cnt;
   int          mid;
   int          prev_mx;
   int          prev_my;
   int          exp_slew;           // Captured settings of the running pulse
   ffp_sample_t exp_sx;
   ffp_sample_t exp_sy;
   bit          hit_x;
   bit          hit_y;

   ff_pulser ff_pulser_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .length   (length),
      .slew_lim (slew_lim),
      .setp_x   (setp_x),
      .setp_y   (setp_y),
      .busy     (busy),
      .out_x    (out_x),
      .out_y    (out_y)
   );

   always #20 clk = ~clk;

   // Hang guard
   always @(posedge clk) begin
      cyc_cnt = cyc_cnt + 1;
      if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
         $display("Run hung, no finish after %0d clock cycles", cyc_cnt);
         $display("Test failures found");
         $fatal(1);
      end
   end

   function automatic int mag_of(input ffp_sample_t s);
      int v;
      v = s;                         // Sign extends
      return (v < 0) ? -v : v;
   endfunction

   // Rise steps of the slower axis rounded up
   function automatic int rise_cycles(input int sx, input int sy, input int slew);
      int m;
      m = (sx < 0) ? -sx : sx;
      if (((sy < 0) ? -sy : sy) > m) m = (sy < 0) ? -sy : sy;
      return (m + slew - 1) / slew;
   endfunction

   task automatic check_value(input string what, input logic signed [63:0] actual,
                              input logic signed [63:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   task automatic scramble_inputs();
      int rnd;
      rnd      = $random(seed);
      length   = rnd;
      rnd      = $random(seed);
      slew_lim = rnd[16:0] | 17'd1;  // Never zero
      rnd      = $random(seed);
      setp_x   = rnd[17:0];
      rnd      = $random(seed);
      setp_y   = rnd[17:0];
   endtask

   // Slew, sign, bound and idle-zero rules for one axis
   task automatic check_axis(input string name, input ffp_sample_t smp,
                             input ffp_sample_t setp, input int prev_m);
      int m;
      int step;
      m    = mag_of(smp);
      step = (m > prev_m) ? m - prev_m : prev_m - m;
      check_value($sformatf("%s step %0d over slew %0d", name, step, exp_slew),
                  longint'(step <= exp_slew), 1);
      check_value($sformatf("%s magnitude %0d over setpoint", name, m),
                  longint'(m <= mag_of(setp)), 1);
      if (smp != '0) begin
         check_value($sformatf("%s sign against setpoint", name), longint'(smp < 0),
                     longint'(setp < 0));
      end
      if (idle_cnt >= ZERO_LAG) begin
         check_value($sformatf("%s not zero after busy fell", name), smp, 0);
      end
   endtask

   // Outputs sampled on the falling edge where they are stable
   task automatic step_cycle();
      @(negedge clk);
      if (busy) idle_cnt = 0;
      else      idle_cnt = idle_cnt + 1;
      check_axis("out_x", out_x, exp_sx, prev_mx);
      check_axis("out_y", out_y, exp_sy, prev_my);
      if (out_x == exp_sx) hit_x = 1'b1;
      if (out_y == exp_sy) hit_y = 1'b1;
      prev_mx = mag_of(out_x);
      prev_my = mag_of(out_y);
   endtask

   initial begin
      int r;
      int m;
      clk       = 1'b0;
      rst_n     = 1'b0;
      start     = 1'b0;
      length    = '0;
      slew_lim  = 17'd1;
      setp_x    = '0;
      setp_y    = '0;
      seed      = 88;
      cyc_cnt   = 0;
      cyc_limit = 0;
      idle_cnt  = ZERO_LAG;
      prev_mx   = 0;
      prev_my   = 0;
      exp_slew  = 0;
      exp_sx    = '0;
      exp_sy    = '0;

      // length, slew, setp_x, setp_y, extra start
      tbl[0] = '{60, 1000, 20000, 15000, 1'b0};       // Both positive
      tbl[1] = '{60, 2500, -30000, -12000, 1'b1};     // Both negative
      tbl[2] = '{80, 1500, 45000, -45000, 1'b0};      // Mixed signs
      tbl[3] = '{30, 100000, 70000, -50000, 1'b0};    // One step to the top
      tbl[4] = '{120, 1000, 2000, -40000, 1'b1};      // Unequal magnitudes
      tbl[5] = '{50, 3000, 0, 24000, 1'b0};           // Idle x axis
      tbl[6] = '{40, 7, -21, 35, 1'b1};
      tbl[7] = '{200, 131071, -131071, 131071, 1'b0}; // Near full scale
      for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
         tbl[i].sx    = $random(seed) % 100000;
         tbl[i].sy    = $random(seed) % 100000;
         m            = mag_of(18'(tbl[i].sx));
         if (mag_of(18'(tbl[i].sy)) > m) m = mag_of(18'(tbl[i].sy));
         tbl[i].slew  = m / 32 + 1 + ($random(seed) & 'hfff);
         r            = rise_cycles(tbl[i].sx, tbl[i].sy, tbl[i].slew);
         tbl[i].length = 2 * r + 12 + ($random(seed) & 63); // Room for rise and fall
         tbl[i].extra = $random(seed) & 1;
      end
      for (int i = 0; i < NUM_ROWS; i++) begin
         cyc_limit = cyc_limit + tbl[i].length + 20;
      end
      cyc_limit = 2 * cyc_limit;

      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      check_value("busy after reset", busy, 0);
      check_value("out_x after reset", out_x, 0);
      check_value("out_y after reset", out_y, 0);

      foreach (tbl[i]) begin
         repeat (3) begin
            scramble_inputs();       // Idle changes must not leak into a pulse
            step_cycle();
         end
         length   = tbl[i].length;
         slew_lim = tbl[i].slew[16:0];
         setp_x   = tbl[i].sx[17:0];
         setp_y   = tbl[i].sy[17:0];
         step_cycle();

         start    = 1'b1;
         exp_slew = tbl[i].slew;
         exp_sx   = tbl[i].sx[17:0];
         exp_sy   = tbl[i].sy[17:0];
         hit_x    = 1'b0;
         hit_y    = 1'b0;
         step_cycle();
         start    = 1'b0;
         check_value($sformatf("row %0d busy one cycle after start", i), busy, 1);

         busy_cnt = 1;
         mid      = tbl[i].length / 2 + 2;
         while (busy) begin
            scramble_inputs();       // Running pulse keeps its shadow copy
            start = tbl[i].extra && (busy_cnt == mid);
            step_cycle();
            if (busy) busy_cnt = busy_cnt + 1;
         end
         start = 1'b0;
         check_value($sformatf("row %0d busy cycles", i), busy_cnt, tbl[i].length + 4);

         repeat (IDLE_GAP) begin
            step_cycle();
            check_value($sformatf("row %0d busy while idle", i), busy, 0);
         end

         r = rise_cycles(tbl[i].sx, tbl[i].sy, tbl[i].slew);
         if (tbl[i].length > 2 * r + 10) begin
            check_value($sformatf("row %0d out_x plateau reached", i), hit_x, 1);
            check_value($sformatf("row %0d out_y plateau reached", i), hit_y, 1);
         end
      end

      $display("All tests passed!");
      $finish;
   end

endmodule : ff_pulser_tb

`default_nettype wire

/* ff_pulser.f */
logic/ffp_pkg.sv
logic/ffp_settings_if.sv
logic/ffp_settings_latch.sv
logic/ffp_sequencer.sv
logic/ffp_slew_channel.sv
logic/ff_pulser.sv
dv/ff_pulser_tb.sv

/* Makefile */
# Verilator build and run for the feedforward pulser testbench

VERILATOR ?= verilator
TOP       ?= ff_pulser_tb
FILELIST  ?= ff_pulser.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
